/* Makefile */
# Verilator flow for the VGA memory testbench

VERILATOR ?= verilator
TOP       ?= vga_mem_tb
FILELIST  ?= vga_mem.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The log decides pass or fail
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/vga_mem_assert.sv */
// ##########################################################
// Bus protocol assertions bound into the VGA memory top
// ##########################################################
`timescale 1ns/1ps

module vga_mem_assert (
  input logic wb_clk_i,
  input logic rst_i,
  input logic data_stb_i,
  input logic data_ack_i,
  input logic cfg_stb_i,
  input logic cfg_ack_i,
  input logic wr_ram_stb_i,
  input logic rd_ram_stb_i
);

  // CPU ack only inside a strobe, single cycle
  ack_in_stb: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    data_ack_i |-> data_stb_i)
    else $error("CPU acknowledge without a strobe");

  ack_single: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    data_ack_i |=> !data_ack_i)
    else $error("CPU acknowledge held for two cycles");

  // Config ack follows the strobe by one cycle
  cfg_ack_follows: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    cfg_ack_i |-> $past(cfg_stb_i))
    else $error("Configuration acknowledge without a strobe the cycle before");

  cfg_ack_due: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    cfg_stb_i |=> cfg_ack_i)
    else $error("Configuration strobe not acknowledged the next cycle");

  // Only one engine on the plane RAM
  one_ram_master: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    !(wr_ram_stb_i && rd_ram_stb_i))
    else $error("Read and write engines strobe the plane RAM together");

endmodule

bind vga_mem vga_mem_assert assert_i (
  .wb_clk_i     (wb_clk_i),
  .rst_i        (rst_i),
  .data_stb_i   (wbs_stb_i),
  .data_ack_i   (wbs_ack_o),
  .cfg_stb_i    (cfg_stb_i),
  .cfg_ack_i    (cfg_ack_o),
  .wr_ram_stb_i (wr_bus.stb),
  .rd_ram_stb_i (rd_bus.stb)
);

/* dv/vga_mem_tb.sv */
// ##########################################################
// Testbench for the VGA graphics memory: register checks and
// a table of CPU accesses checked against a plane model
// ##########################################################
`timescale 1ns/1ps

module vga_mem_tb import vga_mem_pkg::*; ();

  localparam int OFFSET_W = 8;
  localparam int DEPTH    = 1 << OFFSET_W;

  // Words touched by the table
  // First entry doubles as the fold target
  localparam logic [OFFSET_W:0] TEST_ADR [5] = '{9'h005, 9'h010, 9'h023, 9'h047, 9'h09c};

  localparam cfg_reg_e REG_LIST [8] = '{REG_SET_RESET, REG_EN_SET_RESET,
    REG_DATA_ROTATE, REG_READ_MAP, REG_MODE, REG_MISC, REG_BITMASK, REG_MAP_MASK};

  // One CPU access with the configuration it runs under
  typedef struct packed {
    vga_cfg_t          cfg;
    logic              is_read;
    logic [OFFSET_W:0] adr;
    logic [15:0]       dat;
    logic [1:0]        sel;
    logic [15:0]       exp;
  } entry_t;

  logic              wb_clk_i;
  logic              rst_i;
  logic [OFFSET_W:0] wbs_adr_i;
  logic [1:0]        wbs_sel_i;
  logic [15:0]       wbs_dat_i;
  logic              wbs_we_i;
  logic              wbs_stb_i;
  logic [15:0]       wbs_dat_o;
  logic              wbs_ack_o;
  logic [3:0]        cfg_adr_i;
  logic [7:0]        cfg_dat_i;
  logic              cfg_we_i;
  logic              cfg_stb_i;
  logic [7:0]        cfg_dat_o;
  logic              cfg_ack_o;

  entry_t      tab [$];
  string       tab_name [$];
  logic [15:0] ref_plane [NUM_PLANES][DEPTH];
  logic [7:0]  ref_latch [NUM_PLANES];
  vga_cfg_t    shadow;
  logic [31:0] seed = 32'hd0d7_09b5;
  int          cycles = 0;
  int          limit = 1000000;

  vga_mem #(.OFFSET_W(OFFSET_W)) vga_mem_i (
    .wb_clk_i  (wb_clk_i),
    .rst_i     (rst_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_sel_i (wbs_sel_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_dat_o (wbs_dat_o),
    .wbs_ack_o (wbs_ack_o),
    .cfg_adr_i (cfg_adr_i),
    .cfg_dat_i (cfg_dat_i),
    .cfg_we_i  (cfg_we_i),
    .cfg_stb_i (cfg_stb_i),
    .cfg_dat_o (cfg_dat_o),
    .cfg_ack_o (cfg_ack_o)
  );

  // 8 ns clock
  initial begin
    wb_clk_i = 1'b0;
    forever #4 wb_clk_i = ~wb_clk_i;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "run stopped at the first error");
  endtask

  // Cycle watchdog
  always @(posedge wb_clk_i) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      abort_run("Timeout: the run did not finish within its cycle limit");
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Random nonempty byte lane choice
  function automatic logic [1:0] rand_sel();
    logic [31:0] r;
    r = next_rand();
    case (r[23:16] % 3)
      0:       return 2'b01;
      1:       return 2'b10;
      default: return 2'b11;
    endcase
  endfunction

  // Register layout as seen on the configuration port
  function automatic logic [7:0] cfg_byte(input vga_cfg_t c, input cfg_reg_e r);
    case (r)
      REG_SET_RESET:    return {4'h0, c.set_reset};
      REG_EN_SET_RESET: return {4'h0, c.enable_set_reset};
      REG_DATA_ROTATE:  return {3'b000, c.raster_op, 3'b000};
      REG_READ_MAP:     return {6'b000000, c.read_map};
      REG_MODE:         return {6'b000000, c.write_mode};
      REG_MISC:         return {4'h0, c.memory_mapping1, 3'b000};
      REG_BITMASK:      return c.bitmask;
      default:          return {4'h0, c.map_mask};
    endcase
  endfunction

  function automatic logic [OFFSET_W-1:0] map_offset(input vga_cfg_t c,
                                                     input logic [OFFSET_W:0] a);
    // Mapping 1 drops the top offset bit
    if (c.memory_mapping1) begin
      return {1'b0, a[OFFSET_W-2:0]};
    end
    return a[OFFSET_W-1:0];
  endfunction

  // Start pattern mixed from plane and full address
  function automatic logic [15:0] fill_word(input int p, input logic [OFFSET_W:0] a);
    logic [31:0] h;
    h = ({p[1:0], a} + 32'd1) * 32'h9e37_79b9;
    return h[31:16];
  endfunction

  // Plane model updates planes or latches and fills in the expected word
  task automatic model_step(inout entry_t e);
    logic [OFFSET_W-1:0] off;
    logic [15:0]         lat16;
    logic [15:0]         src;
    logic [15:0]         res;
    logic [15:0]         word;
    logic [15:0]         bm16;
    off  = map_offset(e.cfg, e.adr);
    bm16 = {2{e.cfg.bitmask}};
    e.exp = 16'h0000;
    if (e.is_read) begin
      for (int p = 0; p < NUM_PLANES; p++) begin
        ref_latch[p] = (e.sel == 2'b10) ? ref_plane[p][off][15:8] : ref_plane[p][off][7:0];
      end
      e.exp = ref_plane[e.cfg.read_map][off];
    end else begin
      for (int p = 0; p < NUM_PLANES; p++) begin
        lat16 = {2{ref_latch[p]}};
        case (e.cfg.write_mode)
          WM_1: word = lat16;
          WM_2, WM_3: begin
            src  = {{8{e.dat[8+p]}}, {8{e.dat[p]}}};
            word = (src & bm16) | (lat16 & ~bm16);
          end
          default: begin
            src = e.cfg.enable_set_reset[p] ? {16{e.cfg.set_reset[p]}} : e.dat;
            case (e.cfg.raster_op)
              ROP_AND: res = src & lat16;
              ROP_OR:  res = src | lat16;
              ROP_XOR: res = src ^ lat16;
              default: res = src;
            endcase
            word = (res & bm16) | (lat16 & ~bm16);
          end
        endcase
        // Masked planes keep their word
        if (e.cfg.map_mask[p] && e.sel[0]) begin
          ref_plane[p][off][7:0] = word[7:0];
        end
        if (e.cfg.map_mask[p] && e.sel[1]) begin
          ref_plane[p][off][15:8] = word[15:8];
        end
      end
    end
  endtask

  task automatic add_entry(input string name, input vga_cfg_t c, input logic is_read,
                           input logic [OFFSET_W:0] a, input logic [15:0] d,
                           input logic [1:0] s);
    entry_t e;
    e.cfg     = c;
    e.is_read = is_read;
    e.adr     = a;
    e.dat     = d;
    e.sel     = s;
    e.exp     = 16'h0000;
    model_step(e);
    tab.push_back(e);
    tab_name.push_back(name);
  endtask

  // All four planes through read map select
  task automatic add_plane_reads(input string name, input vga_cfg_t c,
                                 input logic [OFFSET_W:0] a);
    vga_cfg_t rc;
    rc = c;
    for (int m = 0; m < NUM_PLANES; m++) begin
      rc.read_map = 2'(m);
      add_entry($sformatf("%s_map%0d", name, m), rc, 1'b1, a, 16'h0000, 2'b11);
    end
  endtask

  task automatic build_table();
    vga_cfg_t          c;
    logic [31:0]       r;
    logic [OFFSET_W:0] a;
    for (int i = 0; i < 5; i++) begin
      for (int p = 0; p < NUM_PLANES; p++) begin
        c = CFG_RESET;
        c.map_mask = 4'(1 << p);
        add_entry("init", c, 1'b0, TEST_ADR[i], fill_word(p, TEST_ADR[i]), 2'b11);
      end
    end
    // Mode 0 with one raster op per address
    for (int op = 0; op < 4; op++) begin
      a = TEST_ADR[op+1];
      c = CFG_RESET;
      add_entry("mode0_latch", c, 1'b1, a, 16'h0000, rand_sel());
      r = next_rand();
      c.raster_op        = raster_op_e'(2'(op));
      c.bitmask          = r[7:0];
      c.enable_set_reset = r[11:8];
      c.set_reset        = r[15:12];
      add_entry($sformatf("mode0_rop%0d_write", op), c, 1'b0, a, r[31:16], rand_sel());
      add_plane_reads($sformatf("mode0_rop%0d", op), c, a);
    end
    // Partial map masks
    for (int k = 0; k < 2; k++) begin
      a = TEST_ADR[k+1];
      c = CFG_RESET;
      add_entry("map_mask_latch", c, 1'b1, a, 16'h0000, 2'b11);
      r = next_rand();
      c.map_mask = (k == 0) ? 4'h5 : 4'hA;
      add_entry("map_mask_write", c, 1'b0, a, r[31:16], 2'b11);
      add_plane_reads($sformatf("map_mask%0d", k), c, a);
    end
    // Mode 1 latch copy from one word to another
    for (int k = 0; k < 2; k++) begin
      c = CFG_RESET;
      add_entry("copy_load", c, 1'b1, TEST_ADR[k+1], 16'h0000, (k == 0) ? 2'b10 : 2'b11);
      r = next_rand();
      c.write_mode = WM_1;
      add_entry("copy_store", c, 1'b0, TEST_ADR[k+3], r[31:16], rand_sel());
      add_plane_reads($sformatf("copy%0d", k), c, TEST_ADR[k+3]);
    end
    // Modes 2 and 3 with a raster op that must be ignored
    r = next_rand();
    for (int m = 2; m < 4; m++) begin
      c = CFG_RESET;
      add_entry("expand_latch", c, 1'b1, TEST_ADR[m], 16'h0000, 2'b11);
      c.write_mode = write_mode_e'(2'(m));
      c.raster_op  = ROP_XOR;
      c.bitmask    = r[7:0];
      add_entry($sformatf("mode%0d_write", m), c, 1'b0, TEST_ADR[m], r[31:16], 2'b11);
      add_plane_reads($sformatf("mode%0d", m), c, TEST_ADR[m]);
    end
    // Mapping 1 folds the upper half onto the lower half
    r = next_rand();
    c = CFG_RESET;
    c.memory_mapping1 = 1'b1;
    add_entry("fold_write", c, 1'b0, TEST_ADR[0] | 9'h080, r[31:16], 2'b11);
    add_plane_reads("fold", c, TEST_ADR[0]);
    add_entry("fold_alias", c, 1'b1, TEST_ADR[0] | 9'h080, 16'h0000, 2'b11);
    c.memory_mapping1 = 1'b0;
    add_entry("fold_plain", c, 1'b1, TEST_ADR[0], 16'h0000, 2'b11);
  endtask

  // Strobe for one cycle and expect the ack on the next
  task automatic cfg_access(input cfg_reg_e r, input logic we, input logic [7:0] d,
                            output logic [7:0] q);
    @(posedge wb_clk_i);
    #1;
    cfg_adr_i = r;
    cfg_dat_i = d;
    cfg_we_i  = we;
    cfg_stb_i = 1'b1;
    @(posedge wb_clk_i);
    #1;
    cfg_stb_i = 1'b0;
    cfg_we_i  = 1'b0;
    @(negedge wb_clk_i);
    if (cfg_ack_o !== 1'b1) begin
      abort_run("Configuration port gave no acknowledge one cycle after its strobe");
    end else begin
      q = cfg_dat_o;
    end
  endtask

  // Write only the registers that change
  task automatic program_cfg(input vga_cfg_t c);
    logic [7:0] q;
    for (int k = 0; k < 8; k++) begin
      if (cfg_byte(c, REG_LIST[k]) != cfg_byte(shadow, REG_LIST[k])) begin
        cfg_access(REG_LIST[k], 1'b1, cfg_byte(c, REG_LIST[k]), q);
      end
    end
    shadow = c;
  endtask

  // Hold the strobe until ack
  task automatic cpu_access(input entry_t e, output logic [15:0] q);
    @(posedge wb_clk_i);
    #1;
    wbs_adr_i = e.adr;
    wbs_dat_i = e.dat;
    wbs_sel_i = e.sel;
    wbs_we_i  = !e.is_read;
    wbs_stb_i = 1'b1;
    @(negedge wb_clk_i);
    while (wbs_ack_o !== 1'b1) begin
      @(negedge wb_clk_i);
    end
    q = wbs_dat_o;
    @(posedge wb_clk_i);
    #1;
    wbs_stb_i = 1'b0;
  endtask

  task automatic check_word(input string name, input logic [15:0] exp,
                            input logic [15:0] act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_cfg(input string name, input cfg_reg_e r, input logic [7:0] exp,
                           input logic [7:0] act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s %s: expected %h, actual %h",
                          name, r.name(), exp, act));
    end
  endtask

  initial begin
    logic [7:0]  q8;
    logic [15:0] q16;
    logic [31:0] r;
    vga_cfg_t    ones;
    rst_i     = 1'b1;
    wbs_adr_i = '0;
    wbs_sel_i = 2'b00;
    wbs_dat_i = 16'h0000;
    wbs_we_i  = 1'b0;
    wbs_stb_i = 1'b0;
    cfg_adr_i = 4'h0;
    cfg_dat_i = 8'h00;
    cfg_we_i  = 1'b0;
    cfg_stb_i = 1'b0;
    build_table();
    limit = tab.size() * 40 + 100;
    repeat (3) @(posedge wb_clk_i);
    #1;
    rst_i = 1'b0;
    // Reset values first and then random values cut to each field
    ones = '1;
    for (int k = 0; k < 8; k++) begin
      cfg_access(REG_LIST[k], 1'b0, 8'h00, q8);
      check_cfg("reset_value", REG_LIST[k], cfg_byte(CFG_RESET, REG_LIST[k]), q8);
    end
    for (int k = 0; k < 8; k++) begin
      r = next_rand();
      cfg_access(REG_LIST[k], 1'b1, r[15:8], q8);
      cfg_access(REG_LIST[k], 1'b0, 8'h00, q8);
      check_cfg("random_value", REG_LIST[k], r[15:8] & cfg_byte(ones, REG_LIST[k]), q8);
    end
    for (int k = 0; k < 8; k++) begin
      cfg_access(REG_LIST[k], 1'b1, cfg_byte(CFG_RESET, REG_LIST[k]), q8);
    end
    shadow = CFG_RESET;
    foreach (tab[i]) begin
      program_cfg(tab[i].cfg);
      cpu_access(tab[i], q16);
      if (tab[i].is_read) begin
        check_word(tab_name[i], tab[i].exp, q16);
      end
    end
    @(posedge wb_clk_i);
    $display("Done: no errors");
    $finish;
  end

endmodule

/* source/vga_bus_mux.sv */
// ##########################################################
// CPU strobe steering and plane RAM sharing between the
// read and write engines
// ##########################################################
`timescale 1ns/1ps

module vga_bus_mux #(
  parameter int OFFSET_W = 8
) (
  input  logic        wb_clk_i,
  input  logic        rst_i,
  input  logic        wbs_we_i,
  input  logic        wbs_stb_i,
  output logic        wr_stb_o,
  output logic        rd_stb_o,
  vga_plane_if.slave  wr_bus,
  vga_plane_if.slave  rd_bus,
  vga_plane_if.master ram_bus
);

  logic       owner_wr;
  logic [1:0] owner_plane;
  logic       locked;
  logic       grant_wr;

  // Plane the owning engine is working on
  assign owner_plane = owner_wr ? wr_bus.adr[OFFSET_W+1 -: 2]
                                : rd_bus.adr[OFFSET_W+1 -: 2];

  // Held while an ack is due or the owner is past plane 0
  assign locked   = ram_bus.ack || (owner_plane != 2'd0);
  assign grant_wr = locked ? owner_wr : wbs_we_i;

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      owner_wr <= 1'b0;
    end else if (!locked) begin
      owner_wr <= wbs_we_i;
    end
  end

  assign wr_stb_o = wbs_stb_i && grant_wr;
  assign rd_stb_o = wbs_stb_i && !grant_wr;

  // Granted engine drives the RAM request
  assign ram_bus.adr   = grant_wr ? wr_bus.adr   : rd_bus.adr;
  assign ram_bus.sel   = grant_wr ? wr_bus.sel   : rd_bus.sel;
  assign ram_bus.dat_w = grant_wr ? wr_bus.dat_w : rd_bus.dat_w;
  assign ram_bus.stb   = grant_wr ? wr_bus.stb   : rd_bus.stb;
  assign ram_bus.we    = grant_wr ? wr_bus.we    : rd_bus.we;

  // Ack goes back to the granted engine only
  assign wr_bus.dat_r = ram_bus.dat_r;
  assign rd_bus.dat_r = ram_bus.dat_r;
  assign wr_bus.ack   = ram_bus.ack && grant_wr;
  assign rd_bus.ack   = ram_bus.ack && !grant_wr;

endmodule

/* source/vga_cfg_regs.sv */
// ##########################################################
// VGA graphics and sequencer registers with one-cycle ack
// ##########################################################
`timescale 1ns/1ps

module vga_cfg_regs import vga_mem_pkg::*; (
  input  logic       wb_clk_i,
  input  logic       rst_i,
  input  cfg_reg_e   cfg_adr_i,
  input  logic [7:0] cfg_dat_i,
  input  logic       cfg_we_i,
  input  logic       cfg_stb_i,
  output logic [7:0] cfg_dat_o,
  output logic       cfg_ack_o,
  output vga_cfg_t   cfg_o
);

  logic [7:0] rd_val;

  // Register write on the strobed edge
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      cfg_o <= CFG_RESET;
    end else if (cfg_stb_i && cfg_we_i) begin
      case (cfg_adr_i)
        REG_SET_RESET:    cfg_o.set_reset        <= cfg_dat_i[3:0];
        REG_EN_SET_RESET: cfg_o.enable_set_reset <= cfg_dat_i[3:0];
        // Function select sits in bits 4:3, rotate count not kept
        REG_DATA_ROTATE:  cfg_o.raster_op        <= raster_op_e'(cfg_dat_i[4:3]);
        REG_READ_MAP:     cfg_o.read_map         <= cfg_dat_i[1:0];
        REG_MODE:         cfg_o.write_mode       <= write_mode_e'(cfg_dat_i[1:0]);
        REG_MISC:         cfg_o.memory_mapping1  <= cfg_dat_i[3];
        REG_BITMASK:      cfg_o.bitmask          <= cfg_dat_i;
        REG_MAP_MASK:     cfg_o.map_mask         <= cfg_dat_i[3:0];
        default:          cfg_o                  <= cfg_o;
      endcase
    end
  end

  // Readback in the same bit positions as the write
  always_comb begin
    case (cfg_adr_i)
      REG_SET_RESET:    rd_val = {4'h0, cfg_o.set_reset};
      REG_EN_SET_RESET: rd_val = {4'h0, cfg_o.enable_set_reset};
      REG_DATA_ROTATE:  rd_val = {3'b000, cfg_o.raster_op, 3'b000};
      REG_READ_MAP:     rd_val = {6'b000000, cfg_o.read_map};
      REG_MODE:         rd_val = {6'b000000, cfg_o.write_mode};
      REG_MISC:         rd_val = {4'h0, cfg_o.memory_mapping1, 3'b000};
      REG_BITMASK:      rd_val = cfg_o.bitmask;
      REG_MAP_MASK:     rd_val = {4'h0, cfg_o.map_mask};
      default:          rd_val = 8'h00;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (cfg_stb_i) begin
      cfg_dat_o <= rd_val;
    end
  end

  // Ack exactly one cycle after the strobe
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      cfg_ack_o <= 1'b0;
    end else begin
      cfg_ack_o <= cfg_stb_i;
    end
  end

endmodule

/* source/vga_mem.sv */
// ##########################################################
// VGA graphics memory top: registers, engines, RAM sharing
// ##########################################################
`timescale 1ns/1ps

module vga_mem import vga_mem_pkg::*; #(
  parameter int OFFSET_W = 8
) (
  input  logic              wb_clk_i,
  input  logic              rst_i,
  input  logic [OFFSET_W:0] wbs_adr_i,
  input  logic [1:0]        wbs_sel_i,
  input  logic [15:0]       wbs_dat_i,
  input  logic              wbs_we_i,
  input  logic              wbs_stb_i,
  output logic [15:0]       wbs_dat_o,
  output logic              wbs_ack_o,
  input  logic [3:0]        cfg_adr_i,
  input  logic [7:0]        cfg_dat_i,
  input  logic              cfg_we_i,
  input  logic              cfg_stb_i,
  output logic [7:0]        cfg_dat_o,
  output logic              cfg_ack_o
);

  vga_cfg_t   cfg;
  logic [7:0] latch [NUM_PLANES];
  logic       wr_stb;
  logic       rd_stb;
  logic       wr_ack;
  logic       rd_ack;

  vga_plane_if #(.OFFSET_W(OFFSET_W)) wr_bus ();
  vga_plane_if #(.OFFSET_W(OFFSET_W)) rd_bus ();
  vga_plane_if #(.OFFSET_W(OFFSET_W)) ram_bus ();

  vga_cfg_regs cfg_regs_i (
    .wb_clk_i  (wb_clk_i),
    .rst_i     (rst_i),
    .cfg_adr_i (cfg_reg_e'(cfg_adr_i)),
    .cfg_dat_i (cfg_dat_i),
    .cfg_we_i  (cfg_we_i),
    .cfg_stb_i (cfg_stb_i),
    .cfg_dat_o (cfg_dat_o),
    .cfg_ack_o (cfg_ack_o),
    .cfg_o     (cfg)
  );

  vga_bus_mux #(.OFFSET_W(OFFSET_W)) bus_mux_i (
    .wb_clk_i  (wb_clk_i),
    .rst_i     (rst_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_stb_i (wbs_stb_i),
    .wr_stb_o  (wr_stb),
    .rd_stb_o  (rd_stb),
    .wr_bus    (wr_bus),
    .rd_bus    (rd_bus),
    .ram_bus   (ram_bus)
  );

  vga_write_iface #(.OFFSET_W(OFFSET_W)) write_iface_i (
    .wb_clk_i  (wb_clk_i),
    .rst_i     (rst_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_sel_i (wbs_sel_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_stb_i (wr_stb),
    .wbs_ack_o (wr_ack),
    .cfg_i     (cfg),
    .latch_i   (latch),
    .wbm       (wr_bus)
  );

  vga_read_iface #(.OFFSET_W(OFFSET_W)) read_iface_i (
    .wb_clk_i  (wb_clk_i),
    .rst_i     (rst_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_sel_i (wbs_sel_i),
    .wbs_stb_i (rd_stb),
    .wbs_dat_o (wbs_dat_o),
    .wbs_ack_o (rd_ack),
    .cfg_i     (cfg),
    .latch_o   (latch),
    .wbm       (rd_bus)
  );

  vga_plane_ram #(.OFFSET_W(OFFSET_W)) plane_ram_i (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .bus      (ram_bus)
  );

  // Only one engine holds the CPU strobe at a time
  assign wbs_ack_o = wr_ack || rd_ack;

endmodule

/* source/vga_mem_pkg.sv */
// ##########################################################
// VGA memory shared types: write modes, raster operations,
// register indices and the graphics configuration word
// ##########################################################
package vga_mem_pkg;

  // Plane logic is built around exactly four planes
  localparam int NUM_PLANES = 4;

  typedef enum logic [1:0] {
    WM_0 = 2'd0,
    WM_1 = 2'd1,
    WM_2 = 2'd2,
    WM_3 = 2'd3
  } write_mode_e;

  // Encoding follows the data rotate register function field
  typedef enum logic [1:0] {
    ROP_NONE = 2'd0,
    ROP_AND  = 2'd1,
    ROP_OR   = 2'd2,
    ROP_XOR  = 2'd3
  } raster_op_e;

  // Graphics controller indices, map mask placed above them
  typedef enum logic [3:0] {
    REG_SET_RESET    = 4'h0,
    REG_EN_SET_RESET = 4'h1,
    REG_DATA_ROTATE  = 4'h3,
    REG_READ_MAP     = 4'h4,
    REG_MODE         = 4'h5,
    REG_MISC         = 4'h6,
    REG_BITMASK      = 4'h8,
    REG_MAP_MASK     = 4'hA
  } cfg_reg_e;

  typedef struct packed {
    logic        memory_mapping1;
    write_mode_e write_mode;
    raster_op_e  raster_op;
    logic [1:0]  read_map;
    logic [7:0]  bitmask;
    logic [3:0]  set_reset;
    logic [3:0]  enable_set_reset;
    logic [3:0]  map_mask;
  } vga_cfg_t;

  // All bits writable through the bitmask, all planes enabled
  localparam vga_cfg_t CFG_RESET = '{
    memory_mapping1:  1'b0,
    write_mode:       WM_0,
    raster_op:        ROP_NONE,
    read_map:         2'd0,
    bitmask:          8'hFF,
    set_reset:        4'h0,
    enable_set_reset: 4'h0,
    map_mask:         4'hF
  };

endpackage

/* source/vga_plane_if.sv */
// ##########################################################
// Plane RAM bus: strobe/acknowledge word access, plane
// number in the top two address bits
// ##########################################################
`timescale 1ns/1ps

interface vga_plane_if #(
  parameter int OFFSET_W = 8
);

  // Plane select above the word offset
  logic [OFFSET_W+1:0] adr;
  logic [1:0]          sel;
  logic [15:0]         dat_w;
  logic [15:0]         dat_r;
  logic                stb;
  logic                we;
  logic                ack;

  // Request side, held steady until ack
  modport master (
    output adr, sel, dat_w, stb, we,
    input  dat_r, ack
  );

  modport slave (
    input  adr, sel, dat_w, stb, we,
    output dat_r, ack
  );

endinterface

/* source/vga_plane_ram.sv */
// ##########################################################
// Four-plane word RAM, byte lane writes, registered ack
// ##########################################################
`timescale 1ns/1ps

module vga_plane_ram import vga_mem_pkg::*; #(
  parameter int OFFSET_W = 8
) (
  input  logic       wb_clk_i,
  input  logic       rst_i,
  vga_plane_if.slave bus
);

  localparam int DEPTH = NUM_PLANES << OFFSET_W;

  logic [15:0] mem [DEPTH];
  logic        take;

  // One access per request, none in the ack cycle
  assign take = bus.stb && !bus.ack;

  always_ff @(posedge wb_clk_i) begin
    if (take) begin
      if (bus.we && bus.sel[0]) begin
        mem[bus.adr][7:0] <= bus.dat_w[7:0];
      end
      if (bus.we && bus.sel[1]) begin
        mem[bus.adr][15:8] <= bus.dat_w[15:8];
      end
      bus.dat_r <= mem[bus.adr];
    end
  end

  // Single-cycle ack, never back to back
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= take;
    end
  end

endmodule

/* source/vga_read_iface.sv */
// ##########################################################
// VGA read engine: loads all four latches, returns the
// plane chosen by read map select
// ##########################################################
`timescale 1ns/1ps

module vga_read_iface import vga_mem_pkg::*; #(
  parameter int OFFSET_W = 8
) (
  input  logic              wb_clk_i,
  input  logic              rst_i,
  input  logic [OFFSET_W:0] wbs_adr_i,
  input  logic [1:0]        wbs_sel_i,
  input  logic              wbs_stb_i,
  output logic [15:0]       wbs_dat_o,
  output logic              wbs_ack_o,
  input  vga_cfg_t          cfg_i,
  output logic [7:0]        latch_o [NUM_PLANES],
  vga_plane_if.master       wbm
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_PLANE,
    RD_DONE
  } rd_state_e;

  rd_state_e           state;
  logic [1:0]          plane;
  logic [OFFSET_W-1:0] offset;
  logic [7:0]          lane_byte;
  logic                plane_ack;

  assign offset = cfg_i.memory_mapping1 ? {1'b0, wbs_adr_i[OFFSET_W-2:0]}
                                        : wbs_adr_i[OFFSET_W-1:0];

  // High lane only for a high-byte access
  assign lane_byte = (wbs_sel_i == 2'b10) ? wbm.dat_r[15:8] : wbm.dat_r[7:0];
  assign plane_ack = (state == RD_PLANE) && wbm.ack;

  // Request goes out from idle so each plane costs two cycles
  assign wbm.adr   = {plane, offset};
  assign wbm.sel   = 2'b11;
  assign wbm.dat_w = 16'h0000;
  assign wbm.stb   = wbs_stb_i && (state != RD_DONE);
  assign wbm.we    = 1'b0;

  assign wbs_ack_o = (state == RD_DONE) && wbs_stb_i;

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      state <= RD_IDLE;
      plane <= 2'd0;
      for (int p = 0; p < NUM_PLANES; p++) begin
        latch_o[p] <= 8'h00;
      end
    end else begin
      case (state)
        RD_IDLE: begin
          if (wbs_stb_i) begin
            state <= RD_PLANE;
          end
        end
        RD_PLANE: begin
          if (wbm.ack) begin
            latch_o[plane] <= lane_byte;
            plane          <= plane + 2'd1;
            if (plane == 2'd3) begin
              state <= RD_DONE;
            end
          end
        end
        // Ack waits for the CPU strobe
        RD_DONE: begin
          if (wbs_stb_i) begin
            state <= RD_IDLE;
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  // Selected plane word kept for the CPU
  always_ff @(posedge wb_clk_i) begin
    if (plane_ack && (plane == cfg_i.read_map)) begin
      wbs_dat_o <= wbm.dat_r;
    end
  end

endmodule

/* source/vga_write_iface.sv */
// ##########################################################
// VGA write engine: modes 0 to 3, set/reset, raster ops,
// bitmask and map mask, stored one plane after another
// ##########################################################
`timescale 1ns/1ps

module vga_write_iface import vga_mem_pkg::*; #(
  parameter int OFFSET_W = 8
) (
  input  logic              wb_clk_i,
  input  logic              rst_i,
  input  logic [OFFSET_W:0] wbs_adr_i,
  input  logic [1:0]        wbs_sel_i,
  input  logic [15:0]       wbs_dat_i,
  input  logic              wbs_stb_i,
  output logic              wbs_ack_o,
  input  vga_cfg_t          cfg_i,
  input  logic [7:0]        latch_i [NUM_PLANES],
  vga_plane_if.master       wbm
);

  logic [15:0]         bitmask16;
  logic [15:0]         plane_word [NUM_PLANES];
  logic [OFFSET_W-1:0] offset;
  logic [1:0]          plane;
  logic                write_en;
  logic                cont;

  // Same mask applies to both byte lanes
  assign bitmask16 = {cfg_i.bitmask, cfg_i.bitmask};

  // Candidate word for every plane
  always_comb begin
    logic [15:0] lat16;
    logic [15:0] src;
    logic [15:0] res;
    for (int p = 0; p < NUM_PLANES; p++) begin
      lat16 = {latch_i[p], latch_i[p]};
      if ((cfg_i.write_mode == WM_2) || (cfg_i.write_mode == WM_3)) begin
        // One data bit per lane spread over the byte, no raster op
        src = {{8{wbs_dat_i[8+p]}}, {8{wbs_dat_i[p]}}};
        res = src;
      end else begin
        // Set/reset bit replaces CPU data where enabled
        if (cfg_i.enable_set_reset[p]) begin
          src = {16{cfg_i.set_reset[p]}};
        end else begin
          src = wbs_dat_i;
        end
        case (cfg_i.raster_op)
          ROP_AND: res = src & lat16;
          ROP_OR:  res = src | lat16;
          ROP_XOR: res = src ^ lat16;
          default: res = src;
        endcase
      end
      // Mode 1 writes the latch back untouched
      if (cfg_i.write_mode == WM_1) begin
        plane_word[p] = lat16;
      end else begin
        plane_word[p] = (res & bitmask16) | (lat16 & ~bitmask16);
      end
    end
  end

  // Mapping 1 folds the upper half onto the lower half
  assign offset = cfg_i.memory_mapping1 ? {1'b0, wbs_adr_i[OFFSET_W-2:0]}
                                        : wbs_adr_i[OFFSET_W-1:0];

  assign write_en = cfg_i.map_mask[plane];

  // Masked plane steps on at once, enabled plane waits for ack
  assign cont      = (wbm.ack || !write_en) && wbs_stb_i;
  assign wbs_ack_o = (plane == 2'd3) && cont;

  assign wbm.adr   = {plane, offset};
  assign wbm.sel   = wbs_sel_i;
  assign wbm.dat_w = plane_word[plane];
  assign wbm.stb   = write_en && wbs_stb_i;
  assign wbm.we    = 1'b1;

  // Plane walk 0 to 3, wraps after the last plane
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      plane <= 2'd0;
    end else if (cont) begin
      plane <= plane + 2'd1;
    end
  end

endmodule

/* vga_mem.f */
source/vga_mem_pkg.sv
source/vga_plane_if.sv
source/vga_cfg_regs.sv
source/vga_bus_mux.sv
source/vga_write_iface.sv
source/vga_read_iface.sv
source/vga_plane_ram.sv
source/vga_mem.sv
dv/vga_mem_assert.sv
dv/vga_mem_tb.sv
